// File: logic/cpu_pkg.sv
package cpu_pkg;

    // Data, instruction and address words
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // Major opcodes, bits 31:26
    localparam logic [5:0] OPCODE_SPECIAL = 6'b000000;
    localparam logic [5:0] OPCODE_ADDIU   = 6'b001001;
    localparam logic [5:0] OPCODE_ANDI    = 6'b001100;
    localparam logic [5:0] OPCODE_ORI     = 6'b001101;
    localparam logic [5:0] OPCODE_XORI    = 6'b001110;
    localparam logic [5:0] OPCODE_LUI     = 6'b001111;
    localparam logic [5:0] OPCODE_LW      = 6'b100011;
    localparam logic [5:0] OPCODE_SW      = 6'b101011;

    // SPECIAL function codes, bits 5:0
    localparam logic [5:0] FUNCT_SLL  = 6'b000000;
    localparam logic [5:0] FUNCT_SRL  = 6'b000010;
    localparam logic [5:0] FUNCT_SRA  = 6'b000011;
    localparam logic [5:0] FUNCT_ADDU = 6'b100001;
    localparam logic [5:0] FUNCT_SUBU = 6'b100011;
    localparam logic [5:0] FUNCT_AND  = 6'b100100;
    localparam logic [5:0] FUNCT_OR   = 6'b100101;
    localparam logic [5:0] FUNCT_XOR  = 6'b100110;
    localparam logic [5:0] FUNCT_NOR  = 6'b100111;
    localparam logic [5:0] FUNCT_SLT  = 6'b101010;

    localparam int    REG_COUNT  = 32;
    localparam addr_t RESET_PC   = 32'h0000_0000;
    localparam addr_t INST_BYTES = 32'd4;

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stall_i,
    input  cpu_pkg::inst_t rom_data_i,
    output cpu_pkg::addr_t rom_addr_o,
    output logic           rom_ce_o,
    output cpu_pkg::addr_t if_pc_o,
    output cpu_pkg::inst_t if_inst_o
);

    cpu_pkg::addr_t pc;
    cpu_pkg::addr_t pc_next;

    assign pc_next    = pc + cpu_pkg::INST_BYTES;
    assign rom_addr_o = pc;

    // Program counter, ROM enabled from the first cycle after reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rom_ce_o <= 1'b0;
            pc       <= cpu_pkg::RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i) begin
                pc <= pc_next;
            end
        end
    end

    // IF/ID register, held during a load-use stall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_pc_o   <= cpu_pkg::RESET_PC;
            if_inst_o <= '0;
        end else if (!stall_i) begin
            if_pc_o   <= pc;
            // Disabled ROM gives an all-zero word, i.e. a nop
            if_inst_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::reg_addr_t read_addr_a_i,
    input  cpu_pkg::reg_addr_t read_addr_b_i,
    output cpu_pkg::word_t     read_data_a_o,
    output cpu_pkg::word_t     read_data_b_o,
    input  logic               write_en_i,
    input  cpu_pkg::reg_addr_t write_addr_i,
    input  cpu_pkg::word_t     write_data_i
);

    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];
    logic           write_valid;

    // r0 is hardwired, writes to it are dropped
    assign write_valid = write_en_i && (write_addr_i != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_valid) begin
            regs[write_addr_i] <= write_data_i;
        end
    end

    // Write-through so writeback needs no separate forwarding path
    always_comb begin
        if (read_addr_a_i == '0) begin
            read_data_a_o = '0;
        end else if (write_valid && (write_addr_i == read_addr_a_i)) begin
            read_data_a_o = write_data_i;
        end else begin
            read_data_a_o = regs[read_addr_a_i];
        end
        if (read_addr_b_i == '0) begin
            read_data_b_o = '0;
        end else if (write_valid && (write_addr_i == read_addr_b_i)) begin
            read_data_b_o = write_data_i;
        end else begin
            read_data_b_o = regs[read_addr_b_i];
        end
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::inst_t     if_inst_i,
    input  cpu_pkg::mem_op_e   ex_mem_op_i,
    input  logic               ex_write_en_i,
    input  cpu_pkg::reg_addr_t ex_write_addr_i,
    input  cpu_pkg::word_t     ex_result_i,
    input  logic               mem_write_en_i,
    input  cpu_pkg::reg_addr_t mem_write_addr_i,
    input  cpu_pkg::word_t     mem_write_data_i,
    input  logic               wb_write_en_i,
    input  cpu_pkg::reg_addr_t wb_write_addr_i,
    input  cpu_pkg::word_t     wb_write_data_i,
    output logic               stall_o,
    output cpu_pkg::alu_op_e   ex_alu_op_o,
    output cpu_pkg::word_t     ex_operand_a_o,
    output cpu_pkg::word_t     ex_operand_b_o,
    output cpu_pkg::word_t     ex_store_data_o,
    output cpu_pkg::mem_op_e   ex_mem_op_o,
    output logic               ex_write_en_o,
    output cpu_pkg::reg_addr_t ex_write_addr_o
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::shamt_t    shamt;
    cpu_pkg::word_t     imm_sext;
    cpu_pkg::word_t     imm_zext;
    cpu_pkg::word_t     rf_data_a;
    cpu_pkg::word_t     rf_data_b;
    cpu_pkg::word_t     rs_value;
    cpu_pkg::word_t     rt_value;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::word_t     operand_a;
    cpu_pkg::word_t     operand_b;
    cpu_pkg::mem_op_e   mem_op;
    logic               write_en;
    cpu_pkg::reg_addr_t write_addr;
    logic               uses_rs;
    logic               uses_rt;

    assign opcode   = if_inst_i[31:26];
    assign rs       = if_inst_i[25:21];
    assign rt       = if_inst_i[20:16];
    assign rd       = if_inst_i[15:11];
    assign shamt    = if_inst_i[10:6];
    assign funct    = if_inst_i[5:0];
    assign imm_sext = {{16{if_inst_i[15]}}, if_inst_i[15:0]};
    assign imm_zext = {16'h0000, if_inst_i[15:0]};

    reg_file reg_file_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .read_addr_a_i(rs),
        .read_addr_b_i(rt),
        .read_data_a_o(rf_data_a),
        .read_data_b_o(rf_data_b),
        .write_en_i   (wb_write_en_i),
        .write_addr_i (wb_write_addr_i),
        .write_data_i (wb_write_data_i)
    );

    // Youngest producer wins: execute, then memory, then register file
    function automatic cpu_pkg::word_t forward(cpu_pkg::reg_addr_t addr,
                                               cpu_pkg::word_t rf_data);
        if (addr == '0) begin
            return '0;
        end else if (ex_write_en_i && (ex_write_addr_i == addr)) begin
            return ex_result_i;
        end else if (mem_write_en_i && (mem_write_addr_i == addr)) begin
            return mem_write_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_value   = forward(rs, rf_data_a);
        rt_value   = forward(rt, rf_data_b);
        alu_op     = cpu_pkg::ALU_ADD;
        operand_a  = rs_value;
        operand_b  = imm_sext;
        mem_op     = cpu_pkg::MEM_NONE;
        write_en   = 1'b1;
        write_addr = rt;
        uses_rs    = 1'b1;
        uses_rt    = 1'b0;
        case (opcode)
            cpu_pkg::OPCODE_SPECIAL: begin
                operand_b  = rt_value;
                write_addr = rd;
                uses_rt    = 1'b1;
                case (funct)
                    cpu_pkg::FUNCT_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FUNCT_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FUNCT_AND:  alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FUNCT_OR:   alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FUNCT_XOR:  alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FUNCT_NOR:  alu_op = cpu_pkg::ALU_NOR;
                    cpu_pkg::FUNCT_SLT:  alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FUNCT_SLL,
                    cpu_pkg::FUNCT_SRL,
                    cpu_pkg::FUNCT_SRA: begin
                        // Shift amount rides on operand A
                        operand_a = {27'd0, shamt};
                        uses_rs   = 1'b0;
                        if (funct == cpu_pkg::FUNCT_SLL) begin
                            alu_op = cpu_pkg::ALU_SLL;
                        end else if (funct == cpu_pkg::FUNCT_SRL) begin
                            alu_op = cpu_pkg::ALU_SRL;
                        end else begin
                            alu_op = cpu_pkg::ALU_SRA;
                        end
                    end
                    default: write_en = 1'b0;
                endcase
            end
            cpu_pkg::OPCODE_ADDIU: alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OPCODE_ANDI: begin
                alu_op    = cpu_pkg::ALU_AND;
                operand_b = imm_zext;
            end
            cpu_pkg::OPCODE_ORI: begin
                alu_op    = cpu_pkg::ALU_OR;
                operand_b = imm_zext;
            end
            cpu_pkg::OPCODE_XORI: begin
                alu_op    = cpu_pkg::ALU_XOR;
                operand_b = imm_zext;
            end
            cpu_pkg::OPCODE_LUI: begin
                alu_op    = cpu_pkg::ALU_LUI;
                operand_b = imm_zext;
                uses_rs   = 1'b0;
            end
            cpu_pkg::OPCODE_LW: mem_op = cpu_pkg::MEM_LOAD;
            cpu_pkg::OPCODE_SW: begin
                mem_op   = cpu_pkg::MEM_STORE;
                write_en = 1'b0;
                uses_rt  = 1'b1;
            end
            default: begin
                write_en = 1'b0;
                uses_rs  = 1'b0;
            end
        endcase
    end

    // Load still in execute, its data is not there until memory
    assign stall_o = (ex_mem_op_i == cpu_pkg::MEM_LOAD) && ex_write_en_i
                     && (ex_write_addr_i != '0)
                     && ((uses_rs && (ex_write_addr_i == rs))
                         || (uses_rt && (ex_write_addr_i == rt)));

    // ID/EX control, a stall inserts a bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_op_o   <= cpu_pkg::MEM_NONE;
            ex_write_en_o <= 1'b0;
        end else if (stall_o) begin
            ex_mem_op_o   <= cpu_pkg::MEM_NONE;
            ex_write_en_o <= 1'b0;
        end else begin
            ex_mem_op_o   <= mem_op;
            ex_write_en_o <= write_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op_o     <= alu_op;
        ex_operand_a_o  <= operand_a;
        ex_operand_b_o  <= operand_b;
        ex_store_data_o <= rt_value;
        ex_write_addr_o <= write_addr;
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::alu_op_e   ex_alu_op_i,
    input  cpu_pkg::word_t     ex_operand_a_i,
    input  cpu_pkg::word_t     ex_operand_b_i,
    input  cpu_pkg::word_t     ex_store_data_i,
    input  cpu_pkg::mem_op_e   ex_mem_op_i,
    input  logic               ex_write_en_i,
    input  cpu_pkg::reg_addr_t ex_write_addr_i,
    output cpu_pkg::word_t     ex_result_o,
    output cpu_pkg::word_t     mem_addr_o,
    output cpu_pkg::word_t     mem_store_data_o,
    output cpu_pkg::mem_op_e   mem_op_o,
    output logic               mem_write_en_o,
    output cpu_pkg::reg_addr_t mem_write_addr_o
);

    cpu_pkg::shamt_t shift_amount;

    assign shift_amount = ex_operand_a_i[4:0];

    // Loads and stores use ALU_ADD, so the result is the address
    always_comb begin
        case (ex_alu_op_i)
            cpu_pkg::ALU_ADD: ex_result_o = ex_operand_a_i + ex_operand_b_i;
            cpu_pkg::ALU_SUB: ex_result_o = ex_operand_a_i - ex_operand_b_i;
            cpu_pkg::ALU_AND: ex_result_o = ex_operand_a_i & ex_operand_b_i;
            cpu_pkg::ALU_OR:  ex_result_o = ex_operand_a_i | ex_operand_b_i;
            cpu_pkg::ALU_XOR: ex_result_o = ex_operand_a_i ^ ex_operand_b_i;
            cpu_pkg::ALU_NOR: ex_result_o = ~(ex_operand_a_i | ex_operand_b_i);
            cpu_pkg::ALU_SLT: begin
                ex_result_o = {31'd0, $signed(ex_operand_a_i) < $signed(ex_operand_b_i)};
            end
            cpu_pkg::ALU_SLL: ex_result_o = ex_operand_b_i << shift_amount;
            cpu_pkg::ALU_SRL: ex_result_o = ex_operand_b_i >> shift_amount;
            cpu_pkg::ALU_SRA: ex_result_o = $signed(ex_operand_b_i) >>> shift_amount;
            cpu_pkg::ALU_LUI: ex_result_o = {ex_operand_b_i[15:0], 16'h0000};
            default:          ex_result_o = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_op_o       <= cpu_pkg::MEM_NONE;
            mem_write_en_o <= 1'b0;
        end else begin
            mem_op_o       <= ex_mem_op_i;
            mem_write_en_o <= ex_write_en_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr_o       <= ex_result_o;
        mem_store_data_o <= ex_store_data_i;
        mem_write_addr_o <= ex_write_addr_i;
    end

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::word_t     mem_addr_i,
    input  cpu_pkg::word_t     mem_store_data_i,
    input  cpu_pkg::mem_op_e   mem_op_i,
    input  logic               mem_write_en_i,
    input  cpu_pkg::reg_addr_t mem_write_addr_i,
    input  cpu_pkg::word_t     ram_read_data_i,
    output cpu_pkg::addr_t     ram_addr_o,
    output cpu_pkg::word_t     ram_write_data_o,
    output logic               ram_write_en_o,
    output logic               ram_ce_o,
    output cpu_pkg::word_t     mem_write_data_o,
    output logic               wb_write_en_o,
    output cpu_pkg::reg_addr_t wb_write_addr_o,
    output cpu_pkg::word_t     wb_write_data_o
);

    logic is_load;

    assign is_load = (mem_op_i == cpu_pkg::MEM_LOAD);

    // RAM answers in the same cycle
    assign ram_ce_o         = (mem_op_i != cpu_pkg::MEM_NONE);
    assign ram_write_en_o   = (mem_op_i == cpu_pkg::MEM_STORE);
    assign ram_addr_o       = mem_addr_i;
    assign ram_write_data_o = mem_store_data_i;

    // Load data replaces the address, also fed to decode for forwarding
    assign mem_write_data_o = is_load ? ram_read_data_i : mem_addr_i;

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_write_en_o <= 1'b0;
        end else begin
            wb_write_en_o <= mem_write_en_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_write_addr_o <= mem_write_addr_i;
        wb_write_data_o <= mem_write_data_o;
    end

endmodule

// File: logic/core.sv
`timescale 1ns/100ps

module core (
    input  logic           clk,
    input  logic           rst_n_i,

    input  cpu_pkg::inst_t rom_data_i,
    output cpu_pkg::addr_t rom_addr_o,
    output logic           rom_ce_o,

    input  cpu_pkg::word_t ram_read_data_i,
    output cpu_pkg::addr_t ram_addr_o,
    output cpu_pkg::word_t ram_write_data_o,
    output logic           ram_write_en_o,
    output logic           ram_ce_o
);

    // IF/ID
    cpu_pkg::inst_t     if_inst;
    logic               stall;

    // ID/EX
    cpu_pkg::alu_op_e   ex_alu_op;
    cpu_pkg::word_t     ex_operand_a;
    cpu_pkg::word_t     ex_operand_b;
    cpu_pkg::word_t     ex_store_data;
    cpu_pkg::mem_op_e   ex_mem_op;
    logic               ex_write_en;
    cpu_pkg::reg_addr_t ex_write_addr;
    cpu_pkg::word_t     ex_result;

    // EX/MEM
    cpu_pkg::word_t     mem_addr;
    cpu_pkg::word_t     mem_store_data;
    cpu_pkg::mem_op_e   mem_op;
    logic               mem_write_en;
    cpu_pkg::reg_addr_t mem_write_addr;
    cpu_pkg::word_t     mem_write_data;

    // MEM/WB
    logic               wb_write_en;
    cpu_pkg::reg_addr_t wb_write_addr;
    cpu_pkg::word_t     wb_write_data;

    fetch_stage fetch_stage_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall),
        .rom_data_i(rom_data_i),
        .rom_addr_o(rom_addr_o),
        .rom_ce_o  (rom_ce_o),
        .if_pc_o   (),
        .if_inst_o (if_inst)
    );

    // ID/EX write fields loop back for forwarding and the load-use check
    decode_stage decode_stage_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .if_inst_i       (if_inst),
        .ex_mem_op_i     (ex_mem_op),
        .ex_write_en_i   (ex_write_en),
        .ex_write_addr_i (ex_write_addr),
        .ex_result_i     (ex_result),
        .mem_write_en_i  (mem_write_en),
        .mem_write_addr_i(mem_write_addr),
        .mem_write_data_i(mem_write_data),
        .wb_write_en_i   (wb_write_en),
        .wb_write_addr_i (wb_write_addr),
        .wb_write_data_i (wb_write_data),
        .stall_o         (stall),
        .ex_alu_op_o     (ex_alu_op),
        .ex_operand_a_o  (ex_operand_a),
        .ex_operand_b_o  (ex_operand_b),
        .ex_store_data_o (ex_store_data),
        .ex_mem_op_o     (ex_mem_op),
        .ex_write_en_o   (ex_write_en),
        .ex_write_addr_o (ex_write_addr)
    );

    execute_stage execute_stage_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_alu_op_i     (ex_alu_op),
        .ex_operand_a_i  (ex_operand_a),
        .ex_operand_b_i  (ex_operand_b),
        .ex_store_data_i (ex_store_data),
        .ex_mem_op_i     (ex_mem_op),
        .ex_write_en_i   (ex_write_en),
        .ex_write_addr_i (ex_write_addr),
        .ex_result_o     (ex_result),
        .mem_addr_o      (mem_addr),
        .mem_store_data_o(mem_store_data),
        .mem_op_o        (mem_op),
        .mem_write_en_o  (mem_write_en),
        .mem_write_addr_o(mem_write_addr)
    );

    memory_stage memory_stage_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .mem_addr_i      (mem_addr),
        .mem_store_data_i(mem_store_data),
        .mem_op_i        (mem_op),
        .mem_write_en_i  (mem_write_en),
        .mem_write_addr_i(mem_write_addr),
        .ram_read_data_i (ram_read_data_i),
        .ram_addr_o      (ram_addr_o),
        .ram_write_data_o(ram_write_data_o),
        .ram_write_en_o  (ram_write_en_o),
        .ram_ce_o        (ram_ce_o),
        .mem_write_data_o(mem_write_data),
        .wb_write_en_o   (wb_write_en),
        .wb_write_addr_o (wb_write_addr),
        .wb_write_data_o (wb_write_data)
    );

endmodule

// File: test/core_properties.sv
`timescale 1ns/100ps

module core_properties (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           rom_ce_i,
    input  cpu_pkg::addr_t rom_addr_i,
    input  logic           ram_ce_i,
    input  logic           ram_write_en_i,
    input  cpu_pkg::addr_t ram_addr_i
);

    // A RAM write only happens inside an enabled access
    write_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_write_en_i |-> ram_ce_i)
        else $error("RAM write enable is high while chip enable is low");

    // Word accesses only
    ram_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_ce_i |-> (ram_addr_i[1:0] == 2'b00))
        else $error("RAM address %h is not word aligned", ram_addr_i);

    rom_idle_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !rom_ce_i)
        else $error("ROM chip enable is high during reset");

    // Fetch address must be clean whenever the ROM is read
    rom_addr_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        rom_ce_i |-> !$isunknown(rom_addr_i))
        else $error("ROM address has unknown bits while enabled");

endmodule

bind core core_properties core_properties_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .rom_ce_i      (rom_ce_o),
    .rom_addr_i    (rom_addr_o),
    .ram_ce_i      (ram_ce_o),
    .ram_write_en_i(ram_write_en_o),
    .ram_addr_i    (ram_addr_o)
);

// File: test/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 5;
    localparam int    RESET_CYCLES = 10;
    localparam int    DRAIN_CYCLES = 8;
    localparam int    ROM_DEPTH    = 256;
    localparam int    RAM_DEPTH    = 1024;
    localparam int    RANDOM_SEED  = 77476;
    localparam string STIM_FILE    = "test/core_stimulus.txt";

    logic           clk = 1'b0;
    logic           rst_n;
    cpu_pkg::inst_t rom_data;
    cpu_pkg::addr_t rom_addr;
    logic           rom_ce;
    cpu_pkg::word_t ram_read_data;
    cpu_pkg::addr_t ram_addr;
    cpu_pkg::word_t ram_write_data;
    logic           ram_write_en;
    logic           ram_ce;

    cpu_pkg::inst_t rom [ROM_DEPTH];
    cpu_pkg::word_t ram [RAM_DEPTH];
    cpu_pkg::addr_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    int             inst_count     = 0;
    int             store_count    = 0;
    int             timeout_cycles = 0;
    logic           stim_loaded    = 1'b0;

    core dut_i (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .rom_data_i      (rom_data),
        .rom_addr_o      (rom_addr),
        .rom_ce_o        (rom_ce),
        .ram_read_data_i (ram_read_data),
        .ram_addr_o      (ram_addr),
        .ram_write_data_o(ram_write_data),
        .ram_write_en_o  (ram_write_en),
        .ram_ce_o        (ram_ce)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer in the same cycle
    assign rom_data      = rom[rom_addr[9:2]];
    assign ram_read_data = ram[ram_addr[11:2]];

    always @(posedge clk) begin
        if (ram_ce && ram_write_en) begin
            ram[ram_addr[11:2]] = ram_write_data;
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // I lines fill the ROM, D lines preset RAM words, E lines queue expected stores
    task automatic load_stimulus();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  tag;
        logic [31:0] first;
        logic [31:0] second;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            $display("Test FAILED");
            $fatal(1, "stimulus file missing");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%c %h %h", tag, first, second);
                if ((tag == "I" && fields < 2) || ((tag == "D" || tag == "E") && fields < 3)) begin
                    $display("Malformed stimulus line: %s", line);
                    $display("Test FAILED");
                    $fatal(1, "bad stimulus line");
                end else begin
                    case (tag)
                        "I": begin
                            rom[inst_count] = first;
                            inst_count++;
                        end
                        "D": ram[first[11:2]] = second;
                        "E": begin
                            exp_addr.push_back(first);
                            exp_data.push_back(second);
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Every RAM write must be the next expected store
    always @(negedge clk) begin
        if (ram_ce && ram_write_en) begin
            if (store_count >= exp_addr.size()) begin
                $display("Unexpected RAM write of %h to %h after the last expected store",
                         ram_write_data, ram_addr);
                $display("Test FAILED");
                $fatal(1, "unexpected RAM write");
            end else begin
                check_value("store address", ram_addr, exp_addr[store_count]);
                check_value("store data", ram_write_data, exp_data[store_count]);
                store_count++;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        void'($urandom(RANDOM_SEED));
        // Unused ROM words are ADDIU r0 writes, which the core discards
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = {16'h2400, i[15:0]};
        end
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram[i] = $urandom();
        end
        load_stimulus();
        timeout_cycles = RESET_CYCLES + 2 * inst_count + 20;
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        // ROM enable is up after the first edge following release
        repeat (2) @(negedge clk);
        check_value("ROM chip enable after reset", rom_ce, 32'd1);

        while (store_count < exp_addr.size()) begin
            @(negedge clk);
        end
        // Let the pipeline drain so a stray write would still be caught
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("Test OK");
        $finish;
    end

    initial begin
        wait (stim_loaded);
        #(timeout_cycles * CLK_PERIOD);
        $display("Timeout: only %0d of %0d expected stores appeared within %0d cycles",
                 store_count, exp_addr.size(), timeout_cycles);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: compile.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/core.sv
test/core_properties.sv
test/core_tb.sv

// File: Makefile
# Verilator build for the MIPS32 core testbench, run from the project root

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		-f compile.f --top-module core_tb -Mdir obj_dir -o Vcore_tb

run: build
	./obj_dir/Vcore_tb

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f compile.f --top-module core_tb

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: test/core_stimulus.txt
# Columns, all hex: I <instruction> | D <byte address> <RAM word> | E <byte address> <store data>
# I lines load the ROM from address 0, E lines list the stores in program order
D 00000200 12345678  # load-use operand
D 00000204 cafef00d  # load then store
I 3c018000  # lui   r1, 0x8000
I 34210001  # ori   r1, r1, 0x0001
I 2402ffff  # addiu r2, r0, -1
I 304300f0  # andi  r3, r2, 0x00f0
I 3824ffff  # xori  r4, r1, 0xffff
I ac010100  # sw    r1, 0x100(r0)
I ac020104  # sw    r2, 0x104(r0)
I ac030108  # sw    r3, 0x108(r0)
I ac04010c  # sw    r4, 0x10c(r0)
I 00222821  # addu  r5, r1, r2
I 00613023  # subu  r6, r3, r1
I 00813824  # and   r7, r4, r1
I 00614025  # or    r8, r3, r1
I 00824826  # xor   r9, r4, r2
I 00615027  # nor   r10, r3, r1
I 0023582a  # slt   r11, r1, r3
I 0062602a  # slt   r12, r3, r2
I 00016900  # sll   r13, r1, 4
I 00017102  # srl   r14, r1, 4
I 00017903  # sra   r15, r1, 4
I ac050110  # sw    r5, 0x110(r0)
I ac060114  # sw    r6, 0x114(r0)
I ac070118  # sw    r7, 0x118(r0)
I ac08011c  # sw    r8, 0x11c(r0)
I ac090120  # sw    r9, 0x120(r0)
I ac0a0124  # sw    r10, 0x124(r0)
I ac0b0128  # sw    r11, 0x128(r0)
I ac0c012c  # sw    r12, 0x12c(r0)
I ac0d0130  # sw    r13, 0x130(r0)
I ac0e0134  # sw    r14, 0x134(r0)
I ac0f0138  # sw    r15, 0x138(r0)
I 24100005  # addiu r16, r0, 5
I 02108821  # addu  r17, r16, r16
I 02309021  # addu  r18, r17, r16
I 02519823  # subu  r19, r18, r17
I 0013a0c0  # sll   r20, r19, 3
I 0293a821  # addu  r21, r20, r19
I ac15013c  # sw    r21, 0x13c(r0)
I 8c160200  # lw    r22, 0x200(r0)
I 02d0b821  # addu  r23, r22, r16
I ac170140  # sw    r23, 0x140(r0)
I 8c180204  # lw    r24, 0x204(r0)
I ac180144  # sw    r24, 0x144(r0)
I 24001234  # addiu r0, r0, 0x1234
I ac000148  # sw    r0, 0x148(r0)
E 00000100 80000001
E 00000104 ffffffff
E 00000108 000000f0
E 0000010c 8000fffe
E 00000110 80000000
E 00000114 800000ef
E 00000118 80000000
E 0000011c 800000f1
E 00000120 7fff0001
E 00000124 7fffff0e
E 00000128 00000001
E 0000012c 00000000
E 00000130 00000010
E 00000134 08000000
E 00000138 f8000000
E 0000013c 0000002d
E 00000140 1234567d
E 00000144 cafef00d
E 00000148 00000000
